// ==== common/ramio_settings.svh ====
/*
 * ramio sizes
 * burst RAM address width, cache geometry and derived widths
 */
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

// burst RAM byte address width
`define RAMIO_RAM_ADDR_BITS 21

// cache geometry: 16 lines of 4 beats, 64 bits per beat
`define RAMIO_LINE_INDEX_BITS 4
`define RAMIO_BEATS 4
`define RAMIO_BEAT_BITS 2         // log2 of RAMIO_BEATS
`define RAMIO_LINE_OFFSET_BITS 5  // 32 bytes per line

// what is left of the byte address for the tag
`define RAMIO_TAG_BITS (`RAMIO_RAM_ADDR_BITS - `RAMIO_LINE_INDEX_BITS - `RAMIO_LINE_OFFSET_BITS)

`endif

// ==== common/ramio_pkg.sv ====
/*
 * ramio_pkg
 * access types of the core side and the line, tag and index types of the cache
 */
`default_nettype none
`include "ramio_settings.svh"

package ramio_pkg;

  // ------------------------------------------------------------------------
  // core side access types
  // ------------------------------------------------------------------------

  // bit 2 set means zero extension
  typedef enum logic [2:0] {
    rd_none   = 3'b000,
    rd_byte   = 3'b001,
    rd_half   = 3'b010,
    rd_word   = 3'b011,
    rd_byte_u = 3'b101,
    rd_half_u = 3'b110
  } read_type_e;

  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } write_type_e;

  // ------------------------------------------------------------------------
  // cache types
  // ------------------------------------------------------------------------

  typedef logic [63:0] beat_t;                                // one burst beat
  typedef logic [`RAMIO_TAG_BITS-1:0] tag_t;
  typedef logic [`RAMIO_LINE_INDEX_BITS-1:0] index_t;
  typedef logic [`RAMIO_BEAT_BITS-1:0] beat_sel_t;            // beat within a line
  typedef logic [`RAMIO_BEAT_BITS:0] word_sel_t;              // 32-bit word within a line

endpackage

`default_nettype wire

// ==== common/line_if.sv ====
/*
 * line_if
 * bundle between the cache controller and the line store
 */
`timescale 1ns/100ps
`default_nettype none

interface line_if;

  // from the controller
  ramio_pkg::index_t index;          // line under access
  ramio_pkg::tag_t tag;              // tag of the request
  ramio_pkg::beat_sel_t beat;        // burst beat, fill and drain
  logic fill_en;                     // write a fill beat
  logic mark_clean;                  // last fill beat, line becomes valid
  ramio_pkg::word_sel_t store_offset;  // word of the line for load and store
  logic [3:0] store_en;              // byte enables of a store merge
  logic [31:0] store_word;

  // from the store
  logic hit;
  logic dirty;                       // line at index needs write-back
  ramio_pkg::tag_t victim_tag;
  logic [31:0] line_word;            // word at store_offset

  modport ctrl (
    output index, tag, beat, fill_en, mark_clean, store_offset, store_en, store_word,
    input  hit, dirty, victim_tag, line_word
  );

  modport store (
    input  index, tag, beat, fill_en, mark_clean, store_offset, store_en, store_word,
    output hit, dirty, victim_tag, line_word
  );

endinterface

`default_nettype wire

// ==== design/byte_lane.sv ====
/*
 * byte_lane
 * load extraction with sign or zero extension, and store lane
 * replication with byte enables, for aligned accesses
 */
`timescale 1ns/100ps
`default_nettype none

module byte_lane (
  input  wire  ramio_pkg::read_type_e  read_type,
  input  wire  ramio_pkg::write_type_e write_type,
  input  wire  [1:0]                   byte_offset,
  input  wire  [31:0]                  line_word,
  input  wire  [31:0]                  data_in,
  output logic [31:0]                  load_data,
  output logic [31:0]                  store_word,
  output logic [3:0]                   store_mask
);

  logic [31:0] shifted;  // addressed byte or half moved to bit 0
  logic        signed_load;

  // --------------------------------------------------------------------------
  // loads
  // --------------------------------------------------------------------------

  assign shifted     = line_word >> {byte_offset, 3'b000};
  assign signed_load = ~read_type[2];  // bit 2 marks the unsigned kinds

  always_comb begin
    case (read_type[1:0])
      2'b01:   load_data = {{24{signed_load & shifted[7]}}, shifted[7:0]};
      2'b10:   load_data = {{16{signed_load & shifted[15]}}, shifted[15:0]};
      2'b11:   load_data = line_word;  // word, offset is 0
      default: load_data = 32'h0;      // no read
    endcase
  end

  // --------------------------------------------------------------------------
  // stores
  // --------------------------------------------------------------------------

  always_comb begin
    store_word = data_in;
    store_mask = 4'b0000;
    case (write_type)
      ramio_pkg::wr_byte: begin
        store_word = {4{data_in[7:0]}};  // every lane carries the byte
        store_mask = 4'b0001 << byte_offset;
      end
      ramio_pkg::wr_half: begin
        store_word = {2{data_in[15:0]}};
        store_mask = byte_offset[1] ? 4'b1100 : 4'b0011;  // upper or lower half
      end
      ramio_pkg::wr_word: begin
        store_mask = 4'b1111;
      end
      default: begin
        store_mask = 4'b0000;  // no write
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== ramio/beat_counter.sv ====
/*
 * beat_counter
 * beat position within a write-back or fill burst
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module beat_counter (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  start,    // next beat is 0
  input  wire                  advance,  // one beat moved
  output ramio_pkg::beat_sel_t beat,
  output logic                 last
);

  always_ff @(posedge clk) begin
    if (reset || start) beat <= '0;
    else if (advance) beat <= last ? '0 : beat + 1'b1;  // wraps after the burst
  end

  assign last = beat == ramio_pkg::beat_sel_t'(`RAMIO_BEATS - 1);

endmodule

`default_nettype wire

// ==== ramio/line_store.sv ====
/*
 * line_store
 * data, tag, valid and dirty state of every cache line, with the hit test,
 * fill and drain by beat, and byte-masked store merge by word
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module line_store (
  input  wire                     clk,
  input  wire                     reset,
  line_if.store                   line,
  input  wire  ramio_pkg::beat_t  br_rd_data,   // fill beat
  output ramio_pkg::beat_t        br_wr_data    // drain beat
);

  localparam int line_count = 1 << `RAMIO_LINE_INDEX_BITS;
  localparam int slot_count = line_count * `RAMIO_BEATS;

  ramio_pkg::beat_t data_q [slot_count];  // beat slots, line index on top
  ramio_pkg::tag_t  tag_q  [line_count];
  logic [line_count-1:0] valid_q;
  logic [line_count-1:0] dirty_q;

  logic [`RAMIO_LINE_INDEX_BITS+`RAMIO_BEAT_BITS-1:0] burst_slot;  // fill and drain
  logic [`RAMIO_LINE_INDEX_BITS+`RAMIO_BEAT_BITS-1:0] word_slot;   // load and store
  ramio_pkg::beat_t word_beat;

  assign burst_slot = {line.index, line.beat};
  assign word_slot  = {line.index, line.store_offset[`RAMIO_BEAT_BITS:1]};

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------

  assign line.hit        = valid_q[line.index] && tag_q[line.index] == line.tag;
  assign line.dirty      = dirty_q[line.index];  // only set on valid lines
  assign line.victim_tag = tag_q[line.index];

  assign word_beat      = data_q[word_slot];
  assign line.line_word = line.store_offset[0] ? word_beat[63:32] : word_beat[31:0];

  assign br_wr_data = data_q[burst_slot];

  // --------------------------------------------------------------------------
  // line data
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (line.fill_en) data_q[burst_slot] <= br_rd_data;
    // fill and store never overlap
    for (int b = 0; b < 4; b++) begin
      if (line.store_en[b]) begin
        data_q[word_slot][line.store_offset[0] * 32 + b * 8 +: 8] <= line.store_word[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line.mark_clean) tag_q[line.index] <= line.tag;  // new owner of the line
  end

  // --------------------------------------------------------------------------
  // line state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;  // all lines invalid
      dirty_q <= '0;
    end else begin
      if (line.mark_clean) begin
        valid_q[line.index] <= 1'b1;
        dirty_q[line.index] <= 1'b0;
      end
      if (|line.store_en) dirty_q[line.index] <= 1'b1;  // needs write-back later
    end
  end

endmodule

`default_nettype wire

// ==== ramio/ramio_ctrl.sv ====
/*
 * ramio_ctrl
 * registers a core request and sequences lookup, write-back of a dirty
 * victim, line fill and the final serve of the access
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module ramio_ctrl (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             enable,
  input  wire  ramio_pkg::read_type_e     read_type,
  input  wire  ramio_pkg::write_type_e    write_type,
  input  wire  [31:0]                     address,
  input  wire  [31:0]                     data_in,
  output logic                            busy,
  output logic                            data_out_ready,
  output logic                            br_cmd,
  output logic                            br_cmd_en,
  output logic [`RAMIO_RAM_ADDR_BITS-1:0] br_addr,
  input  wire                             br_rd_data_valid,
  output logic                            cnt_start,
  output logic                            cnt_advance,
  input  wire                             cnt_last,
  input  wire  ramio_pkg::beat_sel_t      cnt_beat,
  output ramio_pkg::read_type_e           req_read_type,   // to byte_lane
  output ramio_pkg::write_type_e          req_write_type,
  output logic [1:0]                      req_offset,
  output logic [31:0]                     req_data,
  input  wire  [31:0]                     store_word,      // from byte_lane
  input  wire  [3:0]                      store_mask,
  line_if.ctrl                            line
);

  typedef enum logic [2:0] {
    st_idle, st_lookup, st_write_back, st_fill_request, st_fill, st_serve
  } state_e;

  state_e state, state_next;
  logic [`RAMIO_RAM_ADDR_BITS-1:0] req_addr;
  logic accept;     // request taken this cycle
  logic serve_now;  // line present, access completes this cycle

  // --------------------------------------------------------------------------
  // request register
  // --------------------------------------------------------------------------

  assign accept = enable & ~busy;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr       <= address[`RAMIO_RAM_ADDR_BITS-1:0];  // upper bits ignored
      req_read_type  <= read_type;
      req_write_type <= write_type;
      req_data       <= data_in;
    end
  end

  assign req_offset = req_addr[1:0];

  // request fields toward the store
  assign line.index        = req_addr[`RAMIO_LINE_OFFSET_BITS +: `RAMIO_LINE_INDEX_BITS];
  assign line.tag          = req_addr[`RAMIO_RAM_ADDR_BITS-1 -: `RAMIO_TAG_BITS];
  assign line.store_offset = req_addr[`RAMIO_LINE_OFFSET_BITS-1:2];
  assign line.beat         = cnt_beat;
  assign line.store_word   = store_word;

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) state <= st_idle;
    else state <= state_next;
  end

  // serve also checks hit, the tag was written on the last fill beat
  assign serve_now = (state == st_lookup || state == st_serve) && line.hit;

  always_comb begin
    state_next  = state;
    cnt_start   = 1'b0;
    cnt_advance = 1'b0;
    case (state)
      st_idle: if (accept) state_next = st_lookup;
      st_lookup, st_serve: begin
        if (serve_now) state_next = accept ? st_lookup : st_idle;  // back to back ok
        else if (line.dirty) begin
          state_next = st_write_back;
          cnt_start  = 1'b1;  // beat 0 with the write command
        end else state_next = st_fill_request;
      end
      st_write_back: begin
        cnt_advance = 1'b1;  // one beat per cycle, no back-pressure
        if (cnt_last) state_next = st_fill_request;
      end
      st_fill_request: begin
        cnt_start  = 1'b1;
        state_next = st_fill;
      end
      st_fill: begin
        cnt_advance = br_rd_data_valid;
        if (br_rd_data_valid && cnt_last) state_next = st_serve;
      end
      default: state_next = st_idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  assign busy           = ~(state == st_idle || serve_now);
  assign data_out_ready = serve_now && req_read_type != ramio_pkg::rd_none;
  assign line.store_en  = serve_now ? store_mask : 4'b0000;  // merge, marks dirty

  assign line.fill_en    = state == st_fill && br_rd_data_valid;
  assign line.mark_clean = line.fill_en && cnt_last;

  // write command goes out with beat 0 on br_wr_data
  assign br_cmd_en = (state == st_write_back && cnt_beat == '0) || state == st_fill_request;
  assign br_cmd    = state == st_write_back;
  assign br_addr   = {(state == st_write_back) ? line.victim_tag : line.tag, line.index,
                      {`RAMIO_LINE_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

// ==== design/ramio.sv ====
/*
 * ramio
 * memory bridge of the soft core, a direct-mapped write-back cache
 * in front of a burst RAM controller with 64-bit beats
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module ramio (
  input  wire                             clk,
  input  wire                             reset,
  // core side
  input  wire                             enable,          // one cycle, only while !busy
  input  wire  ramio_pkg::read_type_e     read_type,
  input  wire  ramio_pkg::write_type_e    write_type,
  input  wire  [31:0]                     address,
  input  wire  [31:0]                     data_in,
  output logic [31:0]                     data_out,
  output logic                            data_out_ready,
  output logic                            busy,
  // burst RAM side
  output logic                            br_cmd,          // 0 read, 1 write
  output logic                            br_cmd_en,
  output logic [`RAMIO_RAM_ADDR_BITS-1:0] br_addr,         // line aligned
  output ramio_pkg::beat_t                br_wr_data,
  output logic [7:0]                      br_data_mask,
  input  wire  ramio_pkg::beat_t          br_rd_data,
  input  wire                             br_rd_data_valid
);

  logic                   cnt_start, cnt_advance, cnt_last;
  ramio_pkg::beat_sel_t   cnt_beat;
  ramio_pkg::read_type_e  req_read_type;
  ramio_pkg::write_type_e req_write_type;
  logic [1:0]             req_offset;
  logic [31:0]            req_data;
  logic [31:0]            store_word;
  logic [3:0]             store_mask;

  line_if u_line ();

  // --------------------------------------------------------------------------
  // sequencing
  // --------------------------------------------------------------------------

  ramio_ctrl u_ctrl (
    .clk, .reset, .enable, .read_type, .write_type, .address, .data_in,
    .busy, .data_out_ready,
    .br_cmd, .br_cmd_en, .br_addr, .br_rd_data_valid,
    .cnt_start, .cnt_advance, .cnt_last, .cnt_beat,
    .req_read_type, .req_write_type, .req_offset, .req_data,
    .store_word, .store_mask,
    .line(u_line.ctrl)
  );

  beat_counter u_counter (
    .clk, .reset,
    .start(cnt_start), .advance(cnt_advance), .beat(cnt_beat), .last(cnt_last)
  );

  // --------------------------------------------------------------------------
  // data path
  // --------------------------------------------------------------------------

  line_store u_store (
    .clk, .reset, .line(u_line.store), .br_rd_data, .br_wr_data
  );

  byte_lane u_lane (
    .read_type(req_read_type), .write_type(req_write_type), .byte_offset(req_offset),
    .line_word(u_line.line_word), .data_in(req_data),
    .load_data(data_out), .store_word, .store_mask
  );

  assign br_data_mask = 8'h00;  // whole beats only

endmodule

`default_nettype wire

// ==== tb/burst_ram_model.sv ====
/*
 * burst_ram_model
 * behavioral burst RAM with 64-bit beats, four beat bursts and a read
 * latency of 1 to 8 cycles from a seeded LCG
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module burst_ram_model (
  input  wire                             clk,
  input  wire                             br_cmd,           // 0 read, 1 write
  input  wire                             br_cmd_en,
  input  wire  [`RAMIO_RAM_ADDR_BITS-1:0] br_addr,
  input  wire  ramio_pkg::beat_t          br_wr_data,
  input  wire  [7:0]                      br_data_mask,     // set bit keeps the byte
  output ramio_pkg::beat_t                br_rd_data,
  output logic                            br_rd_data_valid
);

  localparam int beat_count = 1 << (`RAMIO_RAM_ADDR_BITS - 3);

  bit [63:0] mem [beat_count];  // 2-state, starts zeroed
  int unsigned lcg_state = 42;
  int wr_left;                   // write beats still to come
  int rd_left;
  int rd_delay;                  // idle cycles before the first read beat
  logic [`RAMIO_RAM_ADDR_BITS-4:0] wr_slot;
  logic [`RAMIO_RAM_ADDR_BITS-4:0] rd_slot;

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;  // wraps mod 2^32
  endfunction

  task automatic store_beat(input logic [`RAMIO_RAM_ADDR_BITS-4:0] slot);
    for (int b = 0; b < 8; b++) begin
      if (!br_data_mask[b]) mem[slot][b*8 +: 8] = br_wr_data[b*8 +: 8];
    end
  endtask

  initial begin
    br_rd_data       = '0;
    br_rd_data_valid = 1'b0;
    wr_left          = 0;
    rd_left          = 0;
    rd_delay         = 0;
    wr_slot          = '0;
    rd_slot          = '0;
  end

  // ------------------------------------------------------------------------
  // one pass per cycle, outputs seen by the bridge at the next rising edge
  // ------------------------------------------------------------------------

  always @(negedge clk) begin
    br_rd_data_valid = 1'b0;
    if (rd_left > 0) begin
      if (rd_delay > 0) rd_delay = rd_delay - 1;
      else begin
        br_rd_data       = mem[rd_slot];  // contiguous once started
        br_rd_data_valid = 1'b1;
        rd_slot          = rd_slot + 1'b1;
        rd_left          = rd_left - 1;
      end
    end
    if (wr_left > 0) begin  // beats 1 to 3 after the command
      store_beat(wr_slot);
      wr_slot = wr_slot + 1'b1;
      wr_left = wr_left - 1;
    end
    if (br_cmd_en) begin
      if (br_cmd) begin
        store_beat(br_addr[`RAMIO_RAM_ADDR_BITS-1:3]);  // beat 0 rides with the command
        wr_slot = br_addr[`RAMIO_RAM_ADDR_BITS-1:3] + 1'b1;
        wr_left = `RAMIO_BEATS - 1;
      end else begin
        lcg_state = lcg_next(lcg_state);
        rd_slot   = br_addr[`RAMIO_RAM_ADDR_BITS-1:3];
        rd_left   = `RAMIO_BEATS;
        rd_delay  = int'((lcg_state >> 16) % 8);  // latency 1 to 8
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/ramio_properties.sv ====
/*
 * ramio_properties
 * handshake rules of the bridge on the core and burst sides, bound into ramio
 */
`timescale 1ns/100ps
`default_nettype none

module ramio_properties (
  input wire clk,
  input wire reset,
  input wire enable,
  input wire busy,
  input wire data_out_ready,
  input wire br_cmd,
  input wire br_cmd_en,
  input wire br_rd_data_valid
);

  int fail_count = 0;  // failed assertions so far

  // ------------------------------------------------------------------------
  // core side
  // ------------------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !busy && !data_out_ready && !br_cmd_en)
    else begin
      $error("bridge not quiet after reset");
      fail_count++;
    end

  // hit answers the cycle after enable, a miss answers as busy falls
  a_ready_free: assert property (@(posedge clk) disable iff (reset)
    data_out_ready |-> !busy && ($past(enable) || $fell(busy)))
    else begin
      $error("read data flagged while busy or with no request behind it");
      fail_count++;
    end

  a_enable_free: assert property (@(posedge clk) disable iff (reset)
    enable |-> !busy)
    else begin
      $error("request issued while busy");
      fail_count++;
    end

  // ------------------------------------------------------------------------
  // burst side, only inside a miss
  // ------------------------------------------------------------------------

  a_cmd_busy: assert property (@(posedge clk) disable iff (reset)
    (br_cmd_en || br_rd_data_valid) |-> busy)
    else begin
      $error("burst activity outside a miss");
      fail_count++;
    end

  // four write beats, then the fill command
  a_write_then_fill: assert property (@(posedge clk) disable iff (reset)
    br_cmd_en && br_cmd |=> !br_cmd_en ##1 !br_cmd_en ##1 !br_cmd_en
                            ##1 (br_cmd_en && !br_cmd))
    else begin
      $error("write-back burst not followed by a fill");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_ramio.sv ====
/*
 * tb_ramio
 * testbench top, plays the core side from the pattern file and
 * checks load data, hit timing and write-back order against burst RAM
 */
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module tb_ramio;

  localparam int fields             = 5;  // op, type, address, data, expected
  localparam int max_patterns       = 64;
  localparam int cycles_per_pattern = 2 * `RAMIO_BEATS + 8 + 6;

  logic                            clk = 1'b0;
  logic                            reset;
  logic                            enable;
  ramio_pkg::read_type_e           read_type;
  ramio_pkg::write_type_e          write_type;
  logic [31:0]                     address;
  logic [31:0]                     data_in;
  logic [31:0]                     data_out;
  logic                            data_out_ready;
  logic                            busy;
  logic                            br_cmd;
  logic                            br_cmd_en;
  logic [`RAMIO_RAM_ADDR_BITS-1:0] br_addr;
  ramio_pkg::beat_t                br_wr_data;
  ramio_pkg::beat_t                br_rd_data;
  logic [7:0]                      br_data_mask;
  logic                            br_rd_data_valid;

  logic [31:0] patterns [0:fields*max_patterns-1];
  int pattern_count;
  int cycle_count = 0;
  int cycle_limit = 0;  // set once the patterns are counted

  always #20 clk = ~clk;  // 40 ns period

  ramio u_ramio (
    .clk, .reset, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  burst_ram_model u_ram (
    .clk, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  bind ramio ramio_properties u_props (
    .clk, .reset, .enable, .busy, .data_out_ready, .br_cmd, .br_cmd_en, .br_rd_data_valid
  );

  // ------------------------------------------------------------------------
  // failure handling and checks
  // ------------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
      abort_run($sformatf("timeout, accesses still running after %0d cycles", cycle_limit));
  end

  // assertion results settle after the rising edge
  always @(negedge clk) begin
    if (u_ramio.u_props.fail_count != 0) abort_run("a handshake assertion failed");
  end

  // type column codes, same numbering as the load kinds
  function automatic ramio_pkg::read_type_e read_kind(input logic [3:0] code);
    case (code)
      4'h1:    return ramio_pkg::rd_byte;
      4'h2:    return ramio_pkg::rd_half;
      4'h3:    return ramio_pkg::rd_word;
      4'h5:    return ramio_pkg::rd_byte_u;
      4'h6:    return ramio_pkg::rd_half_u;
      default: return ramio_pkg::rd_none;
    endcase
  endfunction

  function automatic ramio_pkg::write_type_e write_kind(input logic [3:0] code);
    case (code)
      4'h1:    return ramio_pkg::wr_byte;
      4'h2:    return ramio_pkg::wr_half;
      4'h3:    return ramio_pkg::wr_word;
      default: return ramio_pkg::wr_none;
    endcase
  endfunction

  // one access, entered and left on a falling edge
  task automatic run_access(input int n);
    logic [31:0] op;        // bit 0 write, bit 1 hit, bit 2 write-back
    logic [31:0] kind;
    logic [31:0] expected;
    logic [31:0] line_addr;
    logic        saw_write_back;
    logic        saw_fill;
    string       name;
    op             = patterns[fields*n];
    kind           = patterns[fields*n + 1];
    expected       = patterns[fields*n + 4];
    line_addr      = patterns[fields*n + 2] & 32'h001f_ffe0;  // 21-bit RAM, 32-byte lines
    name           = $sformatf("pattern %0d", n);
    saw_write_back = 1'b0;
    saw_fill       = 1'b0;
    check_value({name, " idle before enable"}, 1'b0, busy);
    enable     = 1'b1;
    address    = patterns[fields*n + 2];
    data_in    = patterns[fields*n + 3];
    read_type  = op[0] ? ramio_pkg::rd_none : read_kind(kind[3:0]);
    write_type = op[0] ? write_kind(kind[3:0]) : ramio_pkg::wr_none;
    @(negedge clk);
    enable     = 1'b0;  // one cycle only
    read_type  = ramio_pkg::rd_none;
    write_type = ramio_pkg::wr_none;
    check_value({name, " busy after enable"}, !op[1], busy);
    while (busy === 1'b1) begin
      check_value({name, " ready while busy"}, 1'b0, data_out_ready);
      if (br_cmd_en && br_cmd) begin
        check_value({name, " write-back after fill"}, 1'b0, saw_fill);
        check_value({name, " write mask"}, 32'h0, br_data_mask);  // all bytes written
        saw_write_back = 1'b1;
      end
      if (br_cmd_en && !br_cmd) begin
        check_value({name, " fill address"}, line_addr, br_addr);
        saw_fill = 1'b1;
      end
      @(negedge clk);
    end
    check_value({name, " data_out_ready"}, !op[0], data_out_ready);
    if (!op[0]) check_value({name, " load data"}, expected, data_out);
    check_value({name, " write-back seen"}, op[2], saw_write_back);
    check_value({name, " fill seen"}, !op[1], saw_fill);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    reset      = 1'b1;
    enable     = 1'b0;
    read_type  = ramio_pkg::rd_none;
    write_type = ramio_pkg::wr_none;
    address    = 32'h0;
    data_in    = 32'h0;
    // unread slots keep a value above every op code
    for (int i = 0; i < fields * max_patterns; i++) patterns[i] = ~i;
    $readmemh("tb/ramio_patterns.txt", patterns);
    pattern_count = 0;
    while (pattern_count < max_patterns && patterns[fields*pattern_count] < 32'd8)
      pattern_count++;
    if (pattern_count == 0) abort_run("no access patterns could be read");
    cycle_limit = pattern_count * cycles_per_pattern + 100;
    repeat (4) @(negedge clk);  // reset over four rising edges
    reset = 1'b0;
    @(negedge clk);
    check_value("reset busy", 1'b0, busy);
    check_value("reset data_out_ready", 1'b0, data_out_ready);
    check_value("reset br_cmd_en", 1'b0, br_cmd_en);
    for (int n = 0; n < pattern_count; n++) run_access(n);
    if (u_ramio.u_props.fail_count != 0) abort_run("a handshake assertion failed");
    else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/ramio_pkg.sv
common/line_if.sv
design/byte_lane.sv
ramio/beat_counter.sv
ramio/line_store.sv
ramio/ramio_ctrl.sv
design/ramio.sv
tb/burst_ram_model.sv
tb/ramio_properties.sv
tb/tb_ramio.sv

// ==== tb/ramio_patterns.txt ====
// op type address data expected, op bit 0 write, bit 1 hit, bit 2 write-back expected
// type 1 byte, 2 half, 3 word, 5 byte unsigned, 6 half unsigned
0 3 00000040 00000000 00000000  // cold miss reads zero
3 3 00000040 12345678 00000000
2 3 00000040 00000000 12345678
3 1 00000041 000000ab 00000000
3 2 00000046 00008001 00000000
2 3 00000040 00000000 1234ab78
2 1 00000041 00000000 ffffffab
2 5 00000041 00000000 000000ab
2 2 00000046 00000000 ffff8001
2 6 00000046 00000000 00008001
2 3 00000044 00000000 80010000
2 1 00000043 00000000 00000012
3 3 0000005c cafef00d 00000000  // last word of the line
4 3 00000240 00000000 00000000  // same index, dirty victim
0 3 00000040 00000000 1234ab78
2 3 0000005c 00000000 cafef00d
2 5 00000047 00000000 00000080
1 2 00000242 00007fff 00000000
4 3 00000040 00000000 1234ab78
0 2 00000242 00000000 00007fff
2 3 00000240 00000000 7fff0000
1 1 00001f03 00000080 00000000
2 1 00001f03 00000000 ffffff80
4 3 00101f00 00000000 00000000  // high tag bits
0 3 00001f00 00000000 80000000
2 6 00001f02 00000000 00008000
2 2 00001f02 00000000 ffff8000
